// ==== pipe_cpu.f ====
+incdir+testbench
src/pipe_cpu_pkg.sv
src/alu.sv
src/reg_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/pipe_cpu.sv
testbench/tb_pipe_cpu.sv

// ==== Bender.yml ====
package:
  name: pipe_cpu

sources:
  - src/pipe_cpu_pkg.sv
  - src/alu.sv
  - src/reg_file.sv
  - src/fetch_stage.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/pipe_cpu.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_pipe_cpu.sv

// ==== testbench/tb_programs.svh ====
/* Directed test programs. Each row holds one instruction word and the register
   write that it retires; destination 0 means that it retires no write */
`ifndef tb_programs_svh
`define tb_programs_svh

task automatic load_table();
    // Sign extension and every ALU op on fixed operands
    test_name[0] = "alu_ops";
    add_row(0, enc_i(1, 0, 100), 1, 32'd100);
    add_row(0, enc_i(2, 0, -7), 2, 32'hffff_fff9);           // Negative immediate
    add_row(0, enc_r(alu_add, 3, 1, 2, 0), 3, 32'd93);
    add_row(0, enc_r(alu_sub, 4, 1, 2, 0), 4, 32'd107);
    add_row(0, enc_r(alu_and, 5, 1, 2, 0), 5, 32'h0000_0060);
    add_row(0, enc_r(alu_or, 6, 1, 2, 0), 6, 32'hffff_fffd);
    add_row(0, enc_r(alu_sll, 7, 1, 0, 3), 7, 32'd800);
    add_row(0, enc_r(alu_sra, 8, 2, 0, 1), 8, 32'hffff_fffc);  // -7 >>> 1

    // Back to back dependencies, one and two instructions apart
    test_name[1] = "forward_chain";
    add_row(1, enc_i(1, 0, 5), 1, 32'd5);
    add_row(1, enc_i(2, 1, 3), 2, 32'd8);
    add_row(1, enc_r(alu_add, 3, 2, 1, 0), 3, 32'd13);
    add_row(1, enc_r(alu_sub, 4, 3, 2, 0), 4, 32'd5);
    add_row(1, enc_r(alu_add, 5, 4, 3, 0), 5, 32'd18);
    add_row(1, enc_r(alu_sll, 6, 5, 0, 2), 6, 32'd72);
    add_row(1, enc_r(alu_sra, 7, 6, 0, 3), 7, 32'd9);
    add_row(1, enc_r(alu_or, 8, 7, 6, 0), 8, 32'd73);

    // Writes to $0 vanish, immediate range limits
    test_name[2] = "reg_zero";
    add_row(2, enc_i(0, 0, 55), 0, '0);
    add_row(2, enc_r(alu_add, 1, 0, 0, 0), 1, 32'd0);
    add_row(2, enc_i(2, 0, 17'h0ffff), 2, 32'h0000_ffff);  // Largest positive
    add_row(2, enc_i(0, 2, 1), 0, '0);
    add_row(2, enc_i(3, 0, 17'h10000), 3, 32'hffff_0000);  // Most negative
    add_row(2, enc_r(alu_or, 4, 0, 3, 0), 4, 32'hffff_0000);
    add_row(2, enc_r(alu_add, 0, 3, 3, 0), 0, '0);
    add_row(2, enc_r(alu_sub, 5, 0, 2, 0), 5, 32'hffff_0001);

    // Slot after each jump is squashed, skipped words never run
    test_name[3] = "jump";
    add_row(3, enc_i(1, 0, 1), 1, 32'd1);
    add_row(3, enc_j(4), 0, '0);
    add_row(3, enc_i(2, 0, 2), 0, '0);                       // Squashed
    add_row(3, enc_i(3, 0, 3), 0, '0);                       // Jumped over
    add_row(3, enc_i(4, 1, 10), 4, 32'd11);
    add_row(3, enc_j(7), 0, '0);
    add_row(3, enc_i(5, 0, 5), 0, '0);                       // Squashed
    add_row(3, enc_r(alu_add, 6, 4, 1, 0), 6, 32'd12);
endtask

`endif

// ==== testbench/tb_pipe_cpu.sv ====
/* Testbench for the pipelined core; runs each table program from reset and
   compares the retired register writes, in order, with the expected list */
`timescale 1ns/1ps

module tb_pipe_cpu import pipe_cpu_pkg::*; ();

    localparam int num_tests  = 5;
    localparam int prog_words = 8;
    localparam int wait_limit = 40;             // Cycles per program

    logic       clock;
    logic       reset;
    pc_t        imem_addr;
    word_t      imem_data;
    reg_write_t reg_write;

    word_t    imem [prog_words];
    string    test_name [num_tests];
    word_t    prog [num_tests][prog_words];
    int       n_instr [num_tests];
    int       exp_count [num_tests];
    reg_idx_t exp_dest [num_tests][prog_words];
    word_t    exp_value [num_tests][prog_words];
    reg_idx_t got_dest [$];                     // Writes seen on the retire port
    word_t    got_value [$];
    integer   seed;
    int       tests_passed;
    int       tests_failed;

    pipe_cpu pipe_cpu_i (.clock, .reset, .imem_addr, .imem_data, .reg_write);

    always #50 clock = ~clock;                  // 100 ns period

    // Past the program end the core sees zero, a no-op
    assign imem_data = (imem_addr < prog_words) ? imem[imem_addr[2:0]] : '0;

    // ------------------------------------------------------------------------
    // Instruction encoding and reference model
    // ------------------------------------------------------------------------
    function automatic word_t enc_r(input alu_op_e op, input reg_idx_t rd,
                                    input reg_idx_t rs, input reg_idx_t rt,
                                    input reg_idx_t sh);
        return {op_rtype, rd, rs, rt, sh, op, 2'b00};
    endfunction

    function automatic word_t enc_i(input reg_idx_t rd, input reg_idx_t rs,
                                    input logic [16:0] imm);
        return {op_addi, rd, rs, imm};
    endfunction

    function automatic word_t enc_j(input logic [26:0] target);
        return {op_jump, target};
    endfunction

    function automatic word_t model_alu(input alu_op_e op, input word_t a,
                                        input word_t b, input reg_idx_t sh);
        case (op)
            alu_add: return a + b;
            alu_sub: return a + ~b + 32'd1;     // Two's complement negate
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_sll: return a << sh;
            alu_sra: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            default: return '0;
        endcase
    endfunction

    // One program word plus the write it retires or dest 0 if none
    task automatic add_row(input int t, input word_t instr, input reg_idx_t dest,
                           input word_t value);
        prog[t][n_instr[t]] = instr;
        n_instr[t]++;
        if (dest != '0) begin
            exp_dest[t][exp_count[t]]  = dest;
            exp_value[t][exp_count[t]] = value;
            exp_count[t]++;
        end
    endtask

    `include "tb_programs.svh"

    // Three random addi seeds, then random R-type ops on r0..r7
    task automatic build_random(input int t);
        word_t       model [32];
        alu_op_e     op;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    sh;
        logic [16:0] imm;
        word_t       res;
        test_name[t] = "random_mix";
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;                      // Matches the cleared register file
        end
        for (int k = 0; k < prog_words; k++) begin
            if (k < 3) begin
                rd  = reg_idx_t'(k + 1);
                imm = 17'($random(seed));
                res = {{15{imm[16]}}, imm};
                add_row(t, enc_i(rd, 0, imm), rd, res);
            end else begin
                rd  = reg_idx_t'(1 + {$random(seed)} % 7);
                op  = alu_op_e'({$random(seed)} % 6);
                rs  = reg_idx_t'({$random(seed)} % 8);
                rt  = reg_idx_t'({$random(seed)} % 8);
                sh  = reg_idx_t'($random(seed));
                res = model_alu(op, model[rs], model[rt], sh);
                add_row(t, enc_r(op, rd, rs, rt, sh), rd, res);
            end
            model[rd] = res;
        end
    endtask

    // ------------------------------------------------------------------------
    // One program from reset to the last retired write
    // ------------------------------------------------------------------------
    task automatic run_test(input int t);
        int cycles;
        int fails;
        fails = 0;
        got_dest.delete();
        got_value.delete();
        @(negedge clock);
        reset = 1'b1;
        for (int i = 0; i < prog_words; i++) begin
            imem[i] = (i < n_instr[t]) ? prog[t][i] : '0;
        end
        @(negedge clock);                       // First reset edge has passed
        assert (imem_addr == '0 && !reg_write.en) else begin
            $display("[ERROR] %s: in reset expected pc 0 en 0, actual pc %0d en %b",
                     test_name[t], imem_addr, reg_write.en);
            fails++;
        end
        repeat (4) @(negedge clock);            // Five reset cycles in total
        reset = 1'b0;
        cycles = 0;
        while (got_dest.size() < exp_count[t] && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
            if (cycles == 1) begin
                assert (imem_addr == '0) else begin
                    $display("[ERROR] %s: first fetch expected 0, actual %0d",
                             test_name[t], imem_addr);
                    fails++;
                end
            end
            if (cycles <= 3) begin              // Pipeline still filling
                assert (!reg_write.en) else begin
                    $display("[ERROR] %s: cycle %0d write enable expected 0, actual 1",
                             test_name[t], cycles);
                    fails++;
                end
            end else if (reg_write.en) begin
                got_dest.push_back(reg_write.dest);
                got_value.push_back(reg_write.value);
            end
        end
        assert (got_dest.size() == exp_count[t]) else begin
            $display("%s: timed out after %0d cycles with %0d of %0d writes retired",
                     test_name[t], cycles, got_dest.size(), exp_count[t]);
            fails++;
        end
        // Nothing else may retire while the pipeline drains
        for (int i = 0; i < 3; i++) begin
            @(posedge clock);
            assert (!reg_write.en) else begin
                $display("%s: stray write to r%0d after the last expected write",
                         test_name[t], reg_write.dest);
                fails++;
            end
        end
        for (int i = 0; i < got_dest.size() && i < exp_count[t]; i++) begin
            assert (got_dest[i] == exp_dest[t][i] && got_value[i] == exp_value[t][i])
            else begin
                $display("[ERROR] %s: write %0d expected r%0d=%h, actual r%0d=%h",
                         test_name[t], i, exp_dest[t][i], exp_value[t][i],
                         got_dest[i], got_value[i]);
                fails++;
            end
        end
        if (fails == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %-14s %s", test_name[t], (fails == 0) ? "ok" : "FAILED");
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        seed         = 93411;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < prog_words; i++) begin
            imem[i] = '0;
        end
        for (int t = 0; t < num_tests; t++) begin
            n_instr[t]   = 0;
            exp_count[t] = 0;
        end
        load_table();
        build_random(4);
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src/pipe_cpu.sv ====
/* Top of the four-stage core; connects fetch, decode, register file and
   execute, and exposes instruction fetch and the retirement write */
`timescale 1ns/1ps

module pipe_cpu import pipe_cpu_pkg::*; #(
    parameter pc_t reset_pc  = '0,
    parameter int  reg_count = 32
) (
    input  logic       clock,
    input  logic       reset,
    output pc_t        imem_addr,
    input  word_t      imem_data,
    output reg_write_t reg_write                // One retired write per enable
);

    word_t      fd_instr;
    logic       redirect;
    pc_t        redirect_pc;
    reg_idx_t   rs_idx;
    reg_idx_t   rt_idx;
    word_t      rs_data;
    word_t      rt_data;
    dx_t        dx;
    reg_write_t wb;

    fetch_stage #(.reset_pc(reset_pc)) fetch_stage_i (
        .clock, .reset, .redirect, .redirect_pc, .imem_addr, .imem_data, .fd_instr
    );

    decode_stage decode_stage_i (
        .clock, .reset, .fd_instr, .rs_idx, .rt_idx, .rs_data, .rt_data,
        .redirect, .redirect_pc, .dx
    );

    reg_file #(.reg_count(reg_count)) reg_file_i (
        .clock, .reset, .rs_idx, .rt_idx, .rs_data, .rt_data, .wb
    );

    execute_stage execute_stage_i (.clock, .reset, .dx, .wb);

    assign reg_write = wb;                      // Writeback is retirement

endmodule

// ==== src/execute_stage.sv ====
/* Execute stage with writeback forwarding, immediate operand select and
   the execute/writeback register that drives the register write */
`timescale 1ns/1ps

module execute_stage import pipe_cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  dx_t        dx,
    output reg_write_t wb                       // Also loops back for forwarding
);

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_result;

    // Newest value of a source, from writeback if it targets that register
    function automatic word_t fwd(input reg_idx_t idx, input word_t val,
                                  input reg_write_t w);
        if (w.en && w.dest != '0 && w.dest == idx) begin
            return w.value;
        end
        return val;
    endfunction

    // ------------------------------------------------------------------------
    // Operand selection
    // ------------------------------------------------------------------------
    assign op_a     = fwd(dx.rs, dx.rs_val, wb);
    assign op_b_reg = fwd(dx.rt, dx.rt_val, wb);
    assign op_b     = dx.imm_sel ? dx.imm : op_b_reg; // addi takes the immediate

    alu alu_i (
        .op     (dx.alu_op),
        .a      (op_a),
        .b      (op_b),
        .shamt  (dx.shamt),
        .result (alu_result)
    );

    // ------------------------------------------------------------------------
    // Execute/writeback register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.en    <= dx.wr_en;
            wb.dest  <= dx.dest;
            wb.value <= alu_result;
        end
    end

endmodule

// ==== src/decode_stage.sv ====
/* Splits the fetched word into fields, reads the register file, resolves
   jumps and loads the decode/execute register */
`timescale 1ns/1ps

module decode_stage import pipe_cpu_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  word_t    fd_instr,
    output reg_idx_t rs_idx,                    // Register file read ports
    output reg_idx_t rt_idx,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output logic     redirect,                  // To fetch, next PC is the target
    output pc_t      redirect_pc,
    output dx_t      dx
);

    instr_t instr;
    word_t  imm_ext;
    dx_t    dx_next;

    // ------------------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------------------
    assign instr       = fd_instr;
    assign rs_idx      = instr.rs;
    assign rt_idx      = instr.rt;
    assign imm_ext     = {{(xlen-imm_w){fd_instr[imm_w-1]}}, fd_instr[imm_w-1:0]};
    assign redirect_pc = {{(xlen-target_w){1'b0}}, fd_instr[target_w-1:0]};

    // ------------------------------------------------------------------------
    // Opcode decode
    // ------------------------------------------------------------------------
    always_comb begin
        redirect        = 1'b0;
        dx_next.wr_en   = 1'b0;                 // Unknown opcodes write nothing
        dx_next.dest    = instr.rd;
        dx_next.rs      = instr.rs;
        dx_next.rt      = instr.rt;
        dx_next.rs_val  = rs_data;
        dx_next.rt_val  = rt_data;
        dx_next.imm     = imm_ext;
        dx_next.imm_sel = 1'b0;
        dx_next.alu_op  = alu_add;
        dx_next.shamt   = instr.shamt;

        case (instr.opcode)
            op_rtype: begin
                dx_next.wr_en  = (instr.rd != '0); // $0 never written
                dx_next.alu_op = instr.alu_op;
            end
            op_addi: begin
                dx_next.wr_en   = (instr.rd != '0);
                dx_next.imm_sel = 1'b1;         // rs + imm through the adder
            end
            op_jump: begin
                redirect = 1'b1;                // Leaves a non-writing entry
            end
            default: ;
        endcase
    end

    // Decode/execute register, payload loads every cycle
    always_ff @(posedge clock) begin
        dx <= dx_next;
        if (reset) begin
            dx.wr_en <= 1'b0;
        end
    end

endmodule

// ==== src/fetch_stage.sv ====
/* Program counter with increment and jump redirect, plus the fetch/decode
   register that drops the squashed slot */
`timescale 1ns/1ps

module fetch_stage import pipe_cpu_pkg::*; #(
    parameter pc_t reset_pc = '0                // First fetch address
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  redirect,                     // Jump seen in decode
    input  pc_t   redirect_pc,
    output pc_t   imem_addr,
    input  word_t imem_data,                    // Same-cycle instruction word
    output word_t fd_instr
);

    pc_t pc;
    pc_t pc_next;

    // ------------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------------
    assign pc_next   = redirect ? redirect_pc : pc + pc_t'(1);
    assign imem_addr = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;                      // Advances every cycle
        end
    end

    // ------------------------------------------------------------------------
    // Fetch/decode register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            fd_instr <= nop_word;
        end else if (redirect) begin
            fd_instr <= nop_word;               // Squash the word behind the jump
        end else begin
            fd_instr <= imem_data;
        end
    end

endmodule

// ==== src/reg_file.sv ====
/* General purpose register file, two combinational read ports with
   write-through from the single write port, register 0 fixed at zero */
`timescale 1ns/1ps

module reg_file import pipe_cpu_pkg::*; #(
    parameter int reg_count = 32
) (
    input  logic       clock,
    input  logic       reset,
    input  reg_idx_t   rs_idx,
    input  reg_idx_t   rt_idx,
    output word_t      rs_data,
    output word_t      rt_data,
    input  reg_write_t wb                       // Write port from writeback
);

    word_t regs [reg_count];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.dest != '0) begin
            regs[wb.dest] <= wb.value;
        end
    end

    // Reads see a write landing on the same edge
    assign rs_data = (rs_idx == '0)                   ? '0       :
                     (wb.en && wb.dest == rs_idx)     ? wb.value :
                                                        regs[rs_idx];
    assign rt_data = (rt_idx == '0)                   ? '0       :
                     (wb.en && wb.dest == rt_idx)     ? wb.value :
                                                        regs[rt_idx];

endmodule

// ==== src/alu.sv ====
/* Combinational integer unit for add, sub, and, or and the two shifts;
   overflow is not reported */
`timescale 1ns/1ps

module alu import pipe_cpu_pkg::*; (
    input  alu_op_e  op,
    input  word_t    a,
    input  word_t    b,
    input  reg_idx_t shamt,                     // Shift distance, applied to a
    output word_t    result
);

    // ------------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------------
    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;                 // Wraps on overflow
            end
            alu_sub: begin
                result = a - b;                 // a minus b
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_sra: begin
                // Sign bit copied in from the left
                result = word_t'($signed(a) >>> shamt);
            end
            default: begin
                result = '0;                    // Undefined op codes
            end
        endcase
    end

endmodule

// ==== src/pipe_cpu_pkg.sv ====
/* Shared widths, instruction layout, opcode and ALU encodings, and pipeline
   stage structs for the four-stage integer core */
package pipe_cpu_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    parameter int xlen       = 32;              // Data and address width
    parameter int reg_addr_w = 5;               // Register index width
    parameter int imm_w      = 17;              // I-type immediate, bits 16..0
    parameter int target_w   = 27;              // Jump target, bits 26..0

    typedef logic [xlen-1:0]       word_t;
    typedef logic [xlen-1:0]       pc_t;      // Counts instructions, not bytes
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // All-zero word decodes as add $0, $0, $0
    parameter word_t nop_word = '0;

    // ------------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        op_rtype = 5'b00000,
        op_jump  = 5'b00001,
        op_addi  = 5'b00101
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    // R-type view of a 32-bit instruction word
    typedef struct packed {
        opcode_e    opcode;                     // [31:27]
        reg_idx_t   rd;                         // [26:22]
        reg_idx_t   rs;                         // [21:17]
        reg_idx_t   rt;                         // [16:12], top of immediate
        reg_idx_t   shamt;                      // [11:7]
        alu_op_e    alu_op;                     // [6:2]
        logic [1:0] pad;                        // [1:0], ignored
    } instr_t;

    // Decode/execute pipeline register
    typedef struct packed {
        logic     wr_en;                        // Writes a register
        reg_idx_t dest;
        reg_idx_t rs;                           // Source indices for forwarding
        reg_idx_t rt;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;                          // Already sign-extended
        logic     imm_sel;                      // Operand b from immediate
        alu_op_e  alu_op;
        reg_idx_t shamt;
    } dx_t;

    // One register write, also the retirement record
    typedef struct packed {
        logic     en;
        reg_idx_t dest;
        word_t    value;
    } reg_write_t;

endpackage
